//--- vlog.f
+incdir+hdl
hdl/fog_pkg.sv
hdl/fog_input_sync.sv
hdl/fog_err_gen.sv
hdl/fog_rate_integrator.sv
hdl/fog_ramp_gen.sv
hdl/fog_loop_top.sv
verification/fog_clk_gen.sv
verification/fog_loop_tb.sv

//--- verification/fog_loop_tb.sv
// fog closed loop testbench
`timescale 1ns/1ps
`include "fog_macros.svh"

module fog_loop_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 5;
	localparam int FREQ_CNT = 40;
	localparam int HALF = FREQ_CNT / 2;
	localparam int N_TAB = 14;
	localparam int N_RAND = 8;
	localparam int N_ROWS = N_TAB + N_RAND;
	localparam int WATCHDOG_CYCLES = N_ROWS * (HALF + 80) + RST_CYCLES;
	// initial acquisition is done about 55 cycles after the trigger
	localparam int INIT_WINDOW = HALF + 60;
	localparam int STEP_TIMEOUT = HALF + 80;

	typedef struct packed {
		logic signed [`FOG_ADC_BIT-1:0] level;
		logic signed [31:0] offset;
		logic polarity;
		// first acquisition after reset or a polarity flip
		logic init_acq;
		logic signed [31:0] exp_err;
	} row_t;

	logic clk;
	logic rst_n;
	logic i_status;
	logic i_polarity;
	logic i_trig;
	logic [31:0] i_freq_cnt;
	logic signed [31:0] i_err_offset;
	logic signed [`FOG_ADC_BIT-1:0] i_adc_data;
	logic signed [31:0] o_err;
	logic o_step_sync;
	logic signed [31:0] o_rate;
	logic o_rate_valid;
	logic [`FOG_DAC_BIT-1:0] o_dac;

	row_t table_rows [N_TAB];
	int errors;
	int checks;
	logic [31:0] lfsr;
	logic [31:0] bits;

	// reference model state
	logic signed [31:0] m_old;
	logic signed [31:0] m_err;
	logic signed [31:0] m_rate;
	logic [`FOG_DAC_BIT-1:0] m_ramp;
	logic m_flip;

	fog_clk_gen #(
		.PERIOD_NS(CLK_PERIOD),
		.RST_CYCLES(RST_CYCLES)
	) u_clk_gen (
		.o_clk(clk),
		.o_rst_n(rst_n)
	);

	fog_loop_top dut (
		.i_clk(clk),
		.i_rst_n(rst_n),
		.i_status(i_status),
		.i_polarity(i_polarity),
		.i_trig(i_trig),
		.i_freq_cnt(i_freq_cnt),
		.i_err_offset(i_err_offset),
		.i_adc_data(i_adc_data),
		.o_err(o_err),
		.o_step_sync(o_step_sync),
		.o_rate(o_rate),
		.o_rate_valid(o_rate_valid),
		.o_dac(o_dac)
	);

	task automatic check_value(input string what, input logic signed [31:0] got,
			input logic signed [31:0] exp);
		begin
			checks++;
			if (got !== exp) begin
				errors++;
				$display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			end
		end
	endtask

	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		begin
			v = '0;
			for (int i = 0; i < n; i++) begin
				v = {v[30:0], lfsr[0]};
				lfsr = lfsr_next(lfsr);
			end
		end
	endtask

	function automatic row_t make_row(input int level, input int offset, input logic pol,
			input logic init_acq, input int exp_err);
		row_t r;
		r.level = level[`FOG_ADC_BIT-1:0];
		r.offset = offset;
		r.polarity = pol;
		r.init_acq = init_acq;
		r.exp_err = exp_err;
		return r;
	endfunction

	task automatic fill_table();
		begin
			// level, offset, polarity, initial acquisition, expected error
			table_rows[0] = make_row(1000, 0, 1'b0, 1'b1, 0);
			table_rows[1] = make_row(1500, 0, 1'b0, 1'b0, 500);
			table_rows[2] = make_row(1200, 100, 1'b0, 1'b0, 400);
			table_rows[3] = make_row(-2000, 0, 1'b0, 1'b0, -3200);
			// large offsets push the ramp around its wrap
			table_rows[4] = make_row(-2000, 400000, 1'b0, 1'b0, 400000);
			table_rows[5] = make_row(3000, 400000, 1'b0, 1'b0, 405000);
			table_rows[6] = make_row(3000, 400000, 1'b0, 1'b0, 400000);
			table_rows[7] = make_row(500, -300, 1'b0, 1'b0, -2800);
			table_rows[8] = make_row(800, 0, 1'b1, 1'b1, 0);
			table_rows[9] = make_row(700, 50, 1'b1, 1'b0, -50);
			table_rows[10] = make_row(-8192, 0, 1'b1, 1'b0, 8892);
			table_rows[11] = make_row(8191, 0, 1'b1, 1'b0, 16383);
			table_rows[12] = make_row(8191, 0, 1'b0, 1'b1, 0);
			table_rows[13] = make_row(0, 12, 1'b0, 1'b0, -8179);
		end
	endtask

	// one demodulation step of the model
	task automatic model_update(input row_t r);
		logic signed [31:0] lvl;
		logic signed [31:0] shr;
		begin
			lvl = $signed(r.level);
			if (m_flip) begin
				m_err = m_old - lvl + r.offset;
			end else begin
				m_err = lvl - m_old + r.offset;
			end
			m_flip = ~m_flip;
			m_old = lvl;
			m_rate = m_rate + m_err;
			shr = m_rate >>> `FOG_GAIN_SHIFT;
			m_ramp = m_ramp + shr[`FOG_DAC_BIT-1:0];
		end
	endtask

	// flip polarity, then bring status into line
	task automatic restart_polarity(input logic pol);
		begin
			@(negedge clk);
			i_polarity = pol;
			repeat (4) @(negedge clk);
			i_status = pol;
			repeat (4) @(negedge clk);
			m_flip = 1'b0;
		end
	endtask

	task automatic run_row(input row_t r, input int idx, input logic from_table);
		int waited;
		int strobes;
		begin
			if (r.polarity !== i_polarity) begin
				restart_polarity(r.polarity);
			end
			@(negedge clk);
			i_adc_data = r.level;
			i_err_offset = r.offset;
			i_trig = 1'b1;
			@(negedge clk);
			i_trig = 1'b0;
			if (r.init_acq) begin
				strobes = 0;
				repeat (INIT_WINDOW) begin
					@(negedge clk);
					if (o_step_sync) begin
						strobes++;
					end
				end
				check_value($sformatf("row %0d step strobes", idx), strobes, 0);
				m_old = $signed(r.level);
				m_flip = 1'b0;
			end else begin
				waited = 0;
				while (o_step_sync !== 1'b1 && waited < STEP_TIMEOUT) begin
					@(negedge clk);
					waited++;
				end
				if (o_step_sync !== 1'b1) begin
					errors++;
					$display("row %0d got no step strobe within %0d cycles", idx, STEP_TIMEOUT);
				end else begin
					model_update(r);
					if (from_table) begin
						check_value($sformatf("row %0d error vs table", idx), o_err, r.exp_err);
					end
					check_value($sformatf("row %0d error", idx), o_err, m_err);
					waited = 0;
					while (o_rate_valid !== 1'b1 && waited < 8) begin
						@(negedge clk);
						waited++;
					end
					if (o_rate_valid !== 1'b1) begin
						errors++;
						$display("row %0d got no rate valid strobe after its step", idx);
					end else begin
						check_value($sformatf("row %0d rate", idx), o_rate, m_rate);
						// ramp register follows two cycles after rate valid
						repeat (2) @(negedge clk);
						check_value($sformatf("row %0d dac", idx), o_dac, m_ramp);
					end
				end
			end
		end
	endtask

	initial begin
		i_status = 1'b0;
		i_polarity = 1'b0;
		i_trig = 1'b0;
		i_freq_cnt = FREQ_CNT;
		i_err_offset = '0;
		i_adc_data = '0;
		errors = 0;
		checks = 0;
		lfsr = 32'hc224_2eb4;
		m_old = '0;
		m_err = '0;
		m_rate = '0;
		m_ramp = '0;
		m_flip = 1'b0;
		fill_table();

		wait (rst_n === 1'b1);
		@(negedge clk);
		check_value("reset error", o_err, 0);
		check_value("reset rate", o_rate, 0);
		check_value("reset dac", o_dac, 0);
		check_value("reset step strobe", o_step_sync, 0);
		check_value("reset rate valid", o_rate_valid, 0);

		for (int i = 0; i < N_TAB; i++) begin
			run_row(table_rows[i], i, 1'b1);
		end
		// random levels, 14 lfsr bits each
		for (int i = 0; i < N_RAND; i++) begin
			take_bits(`FOG_ADC_BIT, bits);
			run_row(make_row($signed(bits[`FOG_ADC_BIT-1:0]), 37, i_polarity, 1'b0, 0),
				N_TAB + i, 1'b0);
		end

		repeat (4) @(negedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

//--- verification/fog_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module fog_clk_gen #(
	parameter int PERIOD_NS = 20,
	parameter int RST_CYCLES = 5
) (
	output logic o_clk,
	output logic o_rst_n
);

	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD_NS / 2) o_clk = ~o_clk;
		end
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		o_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge o_clk);
		@(negedge o_clk);
		o_rst_n = 1'b1;
	end

endmodule

//--- hdl/fog_loop_top.sv
// fog closed loop top
`timescale 1ns/1ps
`include "fog_macros.svh"

module fog_loop_top import fog_pkg::*; (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_status,
	input logic i_polarity,
	input logic i_trig,
	input logic [31:0] i_freq_cnt,
	input logic signed [31:0] i_err_offset,
	input logic signed [`FOG_ADC_BIT-1:0] i_adc_data,
	output logic signed [31:0] o_err,
	output logic o_step_sync,
	output logic signed [31:0] o_rate,
	output logic o_rate_valid,
	output logic [`FOG_DAC_BIT-1:0] o_dac
);

	fog_cond_t cond;
	fog_err_t errs;
	fog_rate_t rate;

	fog_input_sync u_input_sync (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_status(i_status),
		.i_polarity(i_polarity),
		.i_trig(i_trig),
		.i_freq_cnt(i_freq_cnt),
		.i_err_offset(i_err_offset),
		.i_adc_data(i_adc_data),
		.o_cond(cond)
	);

	fog_err_gen u_err_gen (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_cond(cond),
		.o_err(errs)
	);

	fog_rate_integrator u_rate_integrator (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_err(errs),
		.o_rate(rate)
	);

	fog_ramp_gen u_ramp_gen (
		.i_clk(i_clk),
		.i_rst_n(i_rst_n),
		.i_rate(rate),
		.o_dac(o_dac)
	);

	// rate word has settled by the time this rises
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rate_valid <= 1'b0;
		end else begin
			o_rate_valid <= errs.rate_sync;
		end
	end

	assign o_err = errs.err;
	assign o_step_sync = errs.step_sync;
	assign o_rate = rate.rate;

endmodule

//--- hdl/fog_ramp_gen.sv
// fog serrodyne ramp generator
`timescale 1ns/1ps
`include "fog_macros.svh"

module fog_ramp_gen import fog_pkg::*; (
	input logic i_clk,
	input logic i_rst_n,
	input fog_rate_t i_rate,
	output logic [`FOG_DAC_BIT-1:0] o_dac
);

	// phase register, the natural wrap is the 2pi reset
	logic [`FOG_DAC_BIT-1:0] phase;
	logic [`FOG_DAC_BIT-1:0] step_u;

	// two's complement step adds the same either way
	assign step_u = $unsigned(i_rate.step);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			phase <= '0;
		end else if (i_rate.ramp_sync) begin
			phase <= phase + step_u;
		end
	end

	assign o_dac = phase;

endmodule

//--- hdl/fog_rate_integrator.sv
// fog rate integrator
`timescale 1ns/1ps
`include "fog_macros.svh"

module fog_rate_integrator import fog_pkg::*; (
	input logic i_clk,
	input logic i_rst_n,
	input fog_err_t i_err,
	output fog_rate_t o_rate
);

	fog_rate_t r_rate;
	logic signed [31:0] rate_next;
	logic signed [31:0] rate_shr;

	// accumulator wraps at 32 bits
	assign rate_next = r_rate.rate + i_err.err;
	// loop gain as an arithmetic shift
	assign rate_shr = rate_next >>> `FOG_GAIN_SHIFT;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_rate <= '0;
		end else begin
			if (i_err.step_sync) begin
				r_rate.rate <= rate_next;
				r_rate.step <= rate_shr[`FOG_DAC_BIT-1:0];
			end
			// ramp strobe follows so the new step is already in place
			r_rate.ramp_sync <= i_err.ramp_sync;
		end
	end

	assign o_rate = r_rate;

endmodule

//--- hdl/fog_err_gen.sv
// fog error signal generator
`timescale 1ns/1ps
`include "fog_macros.svh"

module fog_err_gen import fog_pkg::*; (
	input logic i_clk,
	input logic i_rst_n,
	input fog_cond_t i_cond,
	output fog_err_t o_err
);

	localparam logic [3:0] ST_RST = 4'd0;
	localparam logic [3:0] ST_WAIT_TRIG = 4'd1;
	localparam logic [3:0] ST_SETTLE = 4'd2;
	localparam logic [3:0] ST_ACQ_INIT = 4'd3;
	localparam logic [3:0] ST_ACQ_NEW = 4'd4;
	localparam logic [3:0] ST_ERR = 4'd5;
	localparam logic [3:0] ST_STEP_DLY = 4'd6;
	localparam logic [3:0] ST_RATE = 4'd7;
	localparam logic [3:0] ST_RAMP = 4'd8;
	localparam logic [3:0] ST_WAIT_NEXT = 4'd9;

	localparam int unsigned ACQ_LEN = 1 << `FOG_AVG_LOG2;

	logic [3:0] state;
	logic [3:0] nstate;
	logic [31:0] settle_cnt;
	logic [`FOG_AVG_LOG2:0] acq_cnt;
	logic signed [31:0] adc_sum;
	logic signed [31:0] avg_old;
	logic signed [31:0] avg_new;
	// first acquisition after reset only fills avg_old
	logic init;
	fog_err_t r_err;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_RST;
		end else begin
			state <= nstate;
		end
	end

	always_comb begin
		nstate = state;
		case (state)
			// status level has to agree with the polarity
			ST_RST: begin
				if (i_cond.status == i_cond.polarity) begin
					nstate = ST_WAIT_TRIG;
				end
			end
			ST_WAIT_TRIG: begin
				if (i_cond.trig) begin
					nstate = ST_SETTLE;
				end
			end
			ST_SETTLE: begin
				if (settle_cnt == 32'd0) begin
					nstate = init ? ST_ACQ_INIT : ST_ACQ_NEW;
				end
			end
			ST_ACQ_INIT: begin
				if (acq_cnt == '0 && i_cond.trig) begin
					nstate = ST_SETTLE;
				end
			end
			ST_ACQ_NEW: begin
				if (acq_cnt == '0) begin
					nstate = ST_ERR;
				end
			end
			ST_ERR: nstate = ST_STEP_DLY;
			ST_STEP_DLY: nstate = ST_RATE;
			ST_RATE: nstate = ST_RAMP;
			ST_RAMP: nstate = ST_WAIT_NEXT;
			ST_WAIT_NEXT: begin
				if (i_cond.trig) begin
					nstate = ST_SETTLE;
				end
			end
			default: nstate = ST_RST;
		endcase

		// a polarity flip restarts the whole acquisition
		if (i_cond.pol_change) begin
			nstate = ST_RST;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			settle_cnt <= `FOG_STABLE_RST;
			acq_cnt <= '0;
			adc_sum <= '0;
			avg_old <= '0;
			avg_new <= '0;
			init <= 1'b1;
			r_err <= '0;
		end else begin
			// strobes last one cycle
			r_err.step_sync <= 1'b0;
			r_err.step_sync_dly <= 1'b0;
			r_err.rate_sync <= 1'b0;
			r_err.ramp_sync <= 1'b0;

			// settle length reloads outside the settle phase
			if (state != ST_SETTLE) begin
				settle_cnt <= i_cond.half_period;
			end

			case (state)
				ST_RST: begin
					r_err.flip <= 1'b0;
					init <= 1'b1;
				end
				ST_SETTLE: begin
					adc_sum <= '0;
					acq_cnt <= ACQ_LEN[`FOG_AVG_LOG2:0];
					if (settle_cnt != 32'd0) begin
						settle_cnt <= settle_cnt - 32'd1;
					end
				end
				ST_ACQ_INIT: begin
					init <= 1'b0;
					if (acq_cnt != '0) begin
						acq_cnt <= acq_cnt - 1'b1;
						adc_sum <= adc_sum + i_cond.adc;
					end else begin
						avg_old <= adc_sum >>> `FOG_AVG_LOG2;
					end
				end
				ST_ACQ_NEW: begin
					if (acq_cnt != '0) begin
						acq_cnt <= acq_cnt - 1'b1;
						adc_sum <= adc_sum + i_cond.adc;
					end else begin
						avg_new <= adc_sum >>> `FOG_AVG_LOG2;
					end
				end
				ST_ERR: begin
					// demodulation sign alternates every half period
					if (r_err.flip) begin
						r_err.err <= avg_old - avg_new + i_cond.err_offset;
					end else begin
						r_err.err <= avg_new - avg_old + i_cond.err_offset;
					end
					r_err.flip <= ~r_err.flip;
					avg_old <= avg_new;
					r_err.step_sync <= 1'b1;
				end
				ST_STEP_DLY: r_err.step_sync_dly <= 1'b1;
				ST_RATE: r_err.rate_sync <= 1'b1;
				ST_RAMP: r_err.ramp_sync <= 1'b1;
				default: begin
				end
			endcase
		end
	end

	assign o_err = r_err;

endmodule

//--- hdl/fog_input_sync.sv
// fog input conditioning
`timescale 1ns/1ps
`include "fog_macros.svh"

module fog_input_sync import fog_pkg::*; (
	input logic i_clk,
	input logic i_rst_n,
	input logic i_status,
	input logic i_polarity,
	input logic i_trig,
	input logic [31:0] i_freq_cnt,
	input logic signed [31:0] i_err_offset,
	input logic signed [`FOG_ADC_BIT-1:0] i_adc_data,
	output fog_cond_t o_cond
);

	fog_cond_t r_cond;
	// delayed copy of the registered polarity
	logic r_pol_dly;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_cond <= '0;
			r_pol_dly <= 1'b0;
		end else begin
			// sign extension of the adc word
			r_cond.adc <= {{(32-`FOG_ADC_BIT){i_adc_data[`FOG_ADC_BIT-1]}}, i_adc_data};
			r_cond.status <= i_status;
			r_cond.polarity <= i_polarity;
			r_cond.trig <= i_trig;
			// settle length is half the modulation period
			r_cond.half_period <= i_freq_cnt >> 1;
			r_cond.err_offset <= i_err_offset;

			r_pol_dly <= r_cond.polarity;
			r_cond.pol_change <= r_cond.polarity ^ r_pol_dly;
		end
	end

	assign o_cond = r_cond;

endmodule

//--- hdl/fog_pkg.sv
// fog loop stage types
`include "fog_macros.svh"

package fog_pkg;

	// conditioned inputs, one cycle after the pins
	typedef struct packed {
		logic signed [31:0] adc;
		logic status;
		logic polarity;
		logic trig;
		// frequency count halved
		logic [31:0] half_period;
		logic pol_change;
		logic signed [31:0] err_offset;
	} fog_cond_t;

	// demodulated error and the strobe sequence
	typedef struct packed {
		logic signed [31:0] err;
		logic step_sync;
		logic step_sync_dly;
		logic rate_sync;
		logic ramp_sync;
		// current sign phase
		logic flip;
	} fog_err_t;

	// integrated rate and scaled step height
	typedef struct packed {
		logic signed [31:0] rate;
		logic signed [`FOG_DAC_BIT-1:0] step;
		logic ramp_sync;
	} fog_rate_t;

endpackage

//--- hdl/fog_macros.svh
// fog loop constants
`ifndef FOG_MACROS_SVH
`define FOG_MACROS_SVH

// adc sample width
`define FOG_ADC_BIT 14

// log2 of samples per average, 32 samples
`define FOG_AVG_LOG2 5

// ramp and phase modulator dac width
`define FOG_DAC_BIT 16

// rate word to step height
`define FOG_GAIN_SHIFT 4

// settle count after reset
`define FOG_STABLE_RST 50

`endif
